/* hw/game_geom_pkg.sv */
package game_geom_pkg;

    // screen coordinate, signed so a sprite can sit just off the left or top edge
    typedef logic signed [10:0] coord_t;

    // per-frame step, -16 .. 15
    typedef logic signed [4:0] vel_t;

    // top-left corner of a sprite
    typedef struct packed
    {
        coord_t x;
        coord_t y;
    } sprite_pos_t;

    typedef struct packed
    {
        vel_t dx;
        vel_t dy;
    } sprite_vel_t;

    // sprite rectangle, right and bottom are exclusive
    typedef struct packed
    {
        coord_t left;
        coord_t top;
        coord_t right;
        coord_t bottom;
    } sprite_box_t;

    function automatic sprite_box_t pos_to_box(sprite_pos_t p, int w, int h);
        sprite_box_t b;
        b.left   = p.x;
        b.top    = p.y;
        b.right  = coord_t'(p.x + w);
        b.bottom = coord_t'(p.y + h);
        return b;
    endfunction

endpackage

/* hw/game_ctrl_pkg.sv */
package game_ctrl_pkg;

    // strobes from the game master into one sprite mover
    typedef struct packed
    {
        logic write_xy;      // load start position
        logic write_dxy;     // load velocity from vel_in
        logic enable_update; // frame ticks move the sprite
    } sprite_ctrl_t;

    // end-of-game result, each bit is a level held in its end state
    typedef struct packed
    {
        logic won;
        logic lost;
    } game_status_t;

endpackage

/* hw/sprite_mover.sv */
`timescale 1ns/100ps

module sprite_mover
    import game_geom_pkg::*, game_ctrl_pkg::*;
#(
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480,
    parameter int SPRITE_W = 8,
    parameter int SPRITE_H = 8,
    parameter int X0       = 0,
    parameter int Y0       = 0
)
(
    input  logic         clk,
    input  logic         reset,

    input  sprite_ctrl_t ctrl,
    input  logic         frame_tick,
    input  sprite_vel_t  vel_in,

    output sprite_pos_t  pos,
    output logic         within_screen
);

    localparam sprite_pos_t START_POS = '{x: coord_t'(X0), y: coord_t'(Y0)};

    sprite_vel_t vel;   // current per-frame step
    sprite_box_t box;
    logic        step;

    assign step = frame_tick & ctrl.enable_update;

    // position register
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos <= START_POS;
        end
        else if (ctrl.write_xy)
        begin
            pos <= START_POS;
        end
        else if (step)
        begin
            // old velocity is used even when write_dxy acts on the same edge
            pos.x <= pos.x + coord_t'(vel.dx);
            pos.y <= pos.y + coord_t'(vel.dy);
        end
    end

    // velocity register, may load together with write_xy
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            vel <= '0;
        else if (ctrl.write_dxy)
            vel <= vel_in;
    end

    // whole sprite box must lie on the screen
    assign box = pos_to_box(pos, SPRITE_W, SPRITE_H);

    always_comb
    begin
        within_screen = 1'b1;

        if (box.left < 0 || box.right > SCREEN_W)
            within_screen = 1'b0;

        if (box.top < 0 || box.bottom > SCREEN_H)
            within_screen = 1'b0;
    end

    // the game master never restarts a sprite while it is moving
    write_xy_not_moving: assert property
    (
        @(posedge clk) disable iff (reset)
        !(ctrl.write_xy && ctrl.enable_update)
    )
    else
        $error("sprite_mover: write_xy together with enable_update");

endmodule

/* hw/sprite_collision.sv */
`timescale 1ns/100ps

module sprite_collision
    import game_geom_pkg::*;
#(
    parameter int SPRITE_W = 8,
    parameter int SPRITE_H = 8
)
(
    input  logic        clk,
    input  logic        reset,

    input  sprite_pos_t target_pos,
    input  sprite_pos_t torpedo_pos,

    output logic        collision
);

    sprite_box_t a;
    sprite_box_t b;
    logic        overlap;

    assign a = pos_to_box(target_pos,  SPRITE_W, SPRITE_H);
    assign b = pos_to_box(torpedo_pos, SPRITE_W, SPRITE_H);

    // rectangles overlap unless one lies fully beside or above the other
    assign overlap =    (a.left < b.right ) && (b.left < a.right )
                     && (a.top  < b.bottom) && (b.top  < a.bottom);

    // registered, so the FSM sees a clean hit flag one cycle later
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap;
    end

endmodule

/* hw/end_of_game_timer.sv */
`timescale 1ns/100ps

module end_of_game_timer
#(
    parameter int END_CYCLES = 64
)
(
    input  logic clk,
    input  logic reset,

    input  logic start,
    output logic running
);

    localparam int CW = (END_CYCLES > 1) ? $clog2(END_CYCLES) : 1;

    logic [CW - 1:0] count;

    // count holds the cycles left after the current one, so the
    // end state lasts END_CYCLES cycles in total
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= CW'(END_CYCLES - 1);
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign running = (count != '0);

    start_when_idle: assert property
    (
        @(posedge clk) disable iff (reset)
        start |-> !running
    )
    else
        $error("end_of_game_timer: start while running");

endmodule

/* hw/game_master_fsm.sv */
`timescale 1ns/100ps

module game_master_fsm
    import game_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         key,

    output sprite_ctrl_t target_ctrl,
    output sprite_ctrl_t torpedo_ctrl,

    input  logic         target_within_screen,
    input  logic         torpedo_within_screen,
    input  logic         collision,

    output logic         timer_start,
    input  logic         timer_running,

    output game_status_t status
);

    // one-hot bit positions
    localparam int START_TARGET    = 0;
    localparam int WAIT_KEY        = 1;
    localparam int START_TORPEDO   = 2;
    localparam int WAIT_COLLISION  = 3;
    localparam int START_END_TIMER = 4;
    localparam int GAME_WON        = 5;
    localparam int GAME_LOST       = 6;
    localparam int N_STATES        = 7;

    logic [N_STATES - 1:0] state;
    logic [N_STATES - 1:0] next_state;
    logic                  collision_d;   // hit seen in the cycle before
    logic                  end_of_game;

    assign end_of_game = ~target_within_screen | ~torpedo_within_screen | collision;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision_d <= 1'b0;
        else
            collision_d <= collision;
    end

    always_comb
    begin
        next_state = '0;

        case (1'b1)
            state[START_TARGET]:
                next_state[WAIT_KEY] = 1'b1;

            state[WAIT_KEY]:
                if (key)
                    next_state[START_TORPEDO] = 1'b1;
                else if (end_of_game)
                    next_state[START_END_TIMER] = 1'b1;
                else
                    next_state[WAIT_KEY] = 1'b1;

            state[START_TORPEDO]:
                next_state[WAIT_COLLISION] = 1'b1;

            state[WAIT_COLLISION]:
                if (end_of_game)
                    next_state[START_END_TIMER] = 1'b1;
                else
                    next_state[WAIT_COLLISION] = 1'b1;

            state[START_END_TIMER]:
                if (collision_d)
                    next_state[GAME_WON] = 1'b1;
                else
                    next_state[GAME_LOST] = 1'b1;

            state[GAME_WON]:
                if (timer_running)
                    next_state[GAME_WON] = 1'b1;
                else
                    next_state[START_TARGET] = 1'b1;

            state[GAME_LOST]:
                if (timer_running)
                    next_state[GAME_LOST] = 1'b1;
                else
                    next_state[START_TARGET] = 1'b1;

            default:  // all-zero state right after reset
                next_state[START_TARGET] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= '0;
        else
            state <= next_state;
    end

    // outputs straight from state bits
    assign target_ctrl.write_xy       = state[START_TARGET];
    assign target_ctrl.write_dxy      = state[START_TARGET];
    assign target_ctrl.enable_update  = state[WAIT_KEY] | state[WAIT_COLLISION];

    assign torpedo_ctrl.write_xy      = state[START_TARGET];
    assign torpedo_ctrl.write_dxy     = state[WAIT_KEY] | state[WAIT_COLLISION];  // aim tracking
    assign torpedo_ctrl.enable_update = state[WAIT_COLLISION];

    assign timer_start = state[START_END_TIMER];
    assign status.won  = state[GAME_WON];
    assign status.lost = state[GAME_LOST];

    state_one_hot: assert property
    (
        @(posedge clk) disable iff (reset)
        $onehot(state) || (state == '0 && $past(reset))
    )
    else
        $error("game_master_fsm: state not one-hot");

endmodule

/* hw/game_top.sv */
`timescale 1ns/100ps

module game_top
    import game_geom_pkg::*, game_ctrl_pkg::*;
#(
    parameter int SCREEN_W   = 640,
    parameter int SCREEN_H   = 480,
    parameter int SPRITE_W   = 8,
    parameter int SPRITE_H   = 8,
    parameter int TARGET_X0  = 40,
    parameter int TARGET_Y0  = 40,
    parameter int TARGET_DX  = 3,
    parameter int TARGET_DY  = 1,
    parameter int TORPEDO_X0 = 320,
    parameter int TORPEDO_Y0 = 440,
    parameter int END_CYCLES = 64
)
(
    input  logic         clk,
    input  logic         reset,
    input  logic         frame_tick,
    input  logic         key,
    input  sprite_vel_t  aim,

    output sprite_pos_t  target_pos,
    output sprite_pos_t  torpedo_pos,
    output game_status_t status
);

    // target always reloads its fixed drift
    localparam sprite_vel_t TARGET_VEL = '{dx: vel_t'(TARGET_DX), dy: vel_t'(TARGET_DY)};

    sprite_ctrl_t target_ctrl;
    sprite_ctrl_t torpedo_ctrl;
    logic         target_within_screen;
    logic         torpedo_within_screen;
    logic         collision;
    logic         timer_start;
    logic         timer_running;

    sprite_mover
    #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .SPRITE_W (SPRITE_W),
        .SPRITE_H (SPRITE_H),
        .X0       (TARGET_X0),
        .Y0       (TARGET_Y0)
    )
    target_mover_i
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (target_ctrl),
        .frame_tick    (frame_tick),
        .vel_in        (TARGET_VEL),
        .pos           (target_pos),
        .within_screen (target_within_screen)
    );

    sprite_mover
    #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .SPRITE_W (SPRITE_W),
        .SPRITE_H (SPRITE_H),
        .X0       (TORPEDO_X0),
        .Y0       (TORPEDO_Y0)
    )
    torpedo_mover_i
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (torpedo_ctrl),
        .frame_tick    (frame_tick),
        .vel_in        (aim),          // player's aim
        .pos           (torpedo_pos),
        .within_screen (torpedo_within_screen)
    );

    sprite_collision #(.SPRITE_W (SPRITE_W), .SPRITE_H (SPRITE_H)) collision_i
    (
        .clk         (clk),
        .reset       (reset),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .collision   (collision)
    );

    end_of_game_timer #(.END_CYCLES (END_CYCLES)) timer_i
    (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .running (timer_running)
    );

    game_master_fsm master_i
    (
        .clk                   (clk),
        .reset                 (reset),
        .key                   (key),
        .target_ctrl           (target_ctrl),
        .torpedo_ctrl          (torpedo_ctrl),
        .target_within_screen  (target_within_screen),
        .torpedo_within_screen (torpedo_within_screen),
        .collision             (collision),
        .timer_start           (timer_start),
        .timer_running         (timer_running),
        .status                (status)
    );

endmodule

/* bench/game_tb.sv */
`timescale 1ns/100ps

module game_tb
    import game_geom_pkg::*, game_ctrl_pkg::*;
;

    localparam int SCREEN_W   = 640;
    localparam int SCREEN_H   = 480;
    localparam int SPRITE_W   = 8;
    localparam int SPRITE_H   = 8;
    localparam int END_CYCLES = 16;
    localparam int HIT_TICKS  = 40;   // flight length of the aimed hit
    localparam int MAX_CYCLES = 45 * (1000 + END_CYCLES) + 2000;

    localparam sprite_pos_t TARGET_START  = '{x: 11'sd40,  y: 11'sd40};
    localparam sprite_pos_t TORPEDO_START = '{x: 11'sd320, y: 11'sd440};
    localparam sprite_vel_t TARGET_DRIFT  = '{dx: 5'sd3,   dy: 5'sd1};

    // model states
    localparam int S_ZERO = 0;
    localparam int S_ST   = 1;   // start target
    localparam int S_WK   = 2;   // wait key
    localparam int S_STT  = 3;   // start torpedo
    localparam int S_WC   = 4;   // wait collision
    localparam int S_SET  = 5;   // start end timer
    localparam int S_WON  = 6;
    localparam int S_LOST = 7;

    logic         clk = 1'b0;
    logic         reset;
    logic         frame_tick;
    logic         key;
    sprite_vel_t  aim;
    sprite_pos_t  target_pos;
    sprite_pos_t  torpedo_pos;
    game_status_t status;

    int          m_state;
    sprite_pos_t m_tpos;
    sprite_pos_t m_ppos;
    sprite_vel_t m_tvel;
    sprite_vel_t m_pvel;
    logic        m_coll;
    logic        m_coll_d;
    int          m_end_left;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int tick_density = 0;   // 0 no ticks, n one tick in n cycles on average

    game_top #(.END_CYCLES (END_CYCLES)) game_top_i
    (
        .clk         (clk),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .key         (key),
        .aim         (aim),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .status      (status)
    );

    initial
    begin
        forever
            #5 clk = ~clk;
    end

    function automatic logic on_screen(sprite_pos_t p);
        return int'(p.x) >= 0 && int'(p.x) + SPRITE_W <= SCREEN_W
            && int'(p.y) >= 0 && int'(p.y) + SPRITE_H <= SCREEN_H;
    endfunction

    function automatic logic boxes_touch(sprite_pos_t a, sprite_pos_t b);
        int dx;
        int dy;
        dx = int'(a.x) - int'(b.x);
        dy = int'(a.y) - int'(b.y);
        return (dx < SPRITE_W && -dx < SPRITE_W) && (dy < SPRITE_H && -dy < SPRITE_H);
    endfunction

    function automatic sprite_pos_t moved(sprite_pos_t p, sprite_vel_t v);
        sprite_pos_t r;
        r.x = coord_t'(int'(p.x) + int'(v.dx));
        r.y = coord_t'(int'(p.y) + int'(v.dy));
        return r;
    endfunction

    task automatic model_reset();
        m_state    = S_ZERO;
        m_tpos     = TARGET_START;
        m_ppos     = TORPEDO_START;
        m_tvel     = '0;
        m_pvel     = '0;
        m_coll     = 1'b0;
        m_coll_d   = 1'b0;
        m_end_left = 0;
    endtask

    task automatic model_step();
        int   nxt;
        logic eog;
        logic flying;
        eog    = !on_screen(m_tpos) || !on_screen(m_ppos) || m_coll;
        flying = (m_state == S_WK) || (m_state == S_WC);
        case (m_state)
            S_ST:   nxt = S_WK;
            S_WK:   nxt = key ? S_STT : (eog ? S_SET : S_WK);
            S_STT:  nxt = S_WC;
            S_WC:   nxt = eog ? S_SET : S_WC;
            S_SET:  nxt = m_coll_d ? S_WON : S_LOST;
            S_WON,
            S_LOST:
            begin
                m_end_left--;
                nxt = (m_end_left == 0) ? S_ST : m_state;
            end
            default: nxt = S_ST;
        endcase
        if (m_state == S_SET)
            m_end_left = END_CYCLES;

        m_coll_d = m_coll;
        m_coll   = boxes_touch(m_tpos, m_ppos);   // positions before this edge

        if (m_state == S_ST)
        begin
            m_tpos = TARGET_START;
            m_tvel = TARGET_DRIFT;
            m_ppos = TORPEDO_START;
        end
        else
        begin
            if (frame_tick && flying)
                m_tpos = moved(m_tpos, m_tvel);
            if (frame_tick && m_state == S_WC)
                m_ppos = moved(m_ppos, m_pvel);   // old aim on this edge
        end
        if (flying)
            m_pvel = aim;
        m_state = nxt;
    endtask

    always @(posedge clk or posedge reset)
    begin
        if (reset)
            model_reset();
        else
            model_step();
    end

    // compare in mid cycle, away from both edges
    always @(negedge clk)
    begin
        assert (target_pos == m_tpos)
        else
        begin
            errors++;
            $display("mismatch at %0t: target_pos dut (%0d,%0d) model (%0d,%0d)",
                     $time, target_pos.x, target_pos.y, m_tpos.x, m_tpos.y);
        end
        assert (torpedo_pos == m_ppos)
        else
        begin
            errors++;
            $display("mismatch at %0t: torpedo_pos dut (%0d,%0d) model (%0d,%0d)",
                     $time, torpedo_pos.x, torpedo_pos.y, m_ppos.x, m_ppos.y);
        end
        assert (status.won == (m_state == S_WON) && status.lost == (m_state == S_LOST))
        else
        begin
            errors++;
            $display("mismatch at %0t: status dut won %0b lost %0b, model state %0d",
                     $time, status.won, status.lost, m_state);
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the game did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
        key = 1'b0;
        if (tick_density == 0)
            frame_tick = 1'b0;
        else
            frame_tick = ($urandom % tick_density) == 0;
    endtask

    task automatic wait_state(int s);
        while (m_state != s)
            step_cycle();
    endtask

    task automatic wait_end();
        while (m_state != S_WON && m_state != S_LOST)
            step_cycle();
    endtask

    task automatic check_result(logic expect_won);
        int n;
        n = 0;
        assert (status.won == expect_won && status.lost == !expect_won)
        else
        begin
            errors++;
            $display("game ended with the wrong result at %0t", $time);
        end
        while (status.won || status.lost)
        begin
            n++;
            step_cycle();
        end
        assert (n == END_CYCLES)
        else
        begin
            errors++;
            $display("end pause lasted %0d cycles instead of %0d", n, END_CYCLES);
        end
        step_cycle();   // start target cycle done
        assert (target_pos == TARGET_START && torpedo_pos == TORPEDO_START)
        else
        begin
            errors++;
            $display("sprites not back at their start points after restart");
        end
    endtask

    task automatic launch(sprite_vel_t a);
        aim = a;
        key = 1'b1;
        step_cycle();
    endtask

    task automatic finish_test(string name, int err0);
        tests_run++;
        if (errors == err0)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    initial
    begin
        int          err0;
        int          wins;
        int          w;
        sprite_pos_t p;
        sprite_vel_t a;

        void'($urandom(32'h650b_8e1e));
        model_reset();
        reset = 1'b1;
        frame_tick = 1'b0;
        key = 1'b0;
        aim = '0;

        // reset
        err0 = errors;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        step_cycle();
        step_cycle();
        assert (target_pos == TARGET_START && torpedo_pos == TORPEDO_START)
        else
        begin
            errors++;
            $display("sprites not at their start points after reset");
        end
        finish_test("reset", err0);

        // target drifts off, game lost
        err0 = errors;
        tick_density = 2;
        wait_state(S_WK);
        while (m_state == S_WK)
            step_cycle();
        wait_end();
        tick_density = 0;
        check_result(1'b0);
        finish_test("drift", err0);

        // aim so that relative motion points straight at the target
        err0 = errors;
        wait_state(S_WK);
        a.dx = vel_t'(3 + (40 - 320) / HIT_TICKS);
        a.dy = vel_t'(1 + (40 - 440) / HIT_TICKS);
        launch(a);
        tick_density = 1;
        wait_end();
        tick_density = 0;
        check_result(1'b1);
        finish_test("hit", err0);

        // torpedo off the right edge
        err0 = errors;
        wait_state(S_WK);
        launch('{dx: 5'sd15, dy: 5'sd0});
        tick_density = 1;
        wait_end();
        tick_density = 0;
        check_result(1'b0);
        finish_test("miss", err0);

        // aim changes in flight, stray keys
        err0 = errors;
        wait_state(S_WK);
        launch('{dx: 5'sd0, dy: -5'sd2});
        step_cycle();   // torpedo in flight
        repeat (3)
        begin
            a.dx = vel_t'(int'($urandom % 5) - 2);
            a.dy = vel_t'(-1 - int'($urandom % 4));
            aim = a;
            step_cycle();
            p = m_ppos;
            frame_tick = 1'b1;
            key = 1'b1;
            step_cycle();
            assert (torpedo_pos.x == coord_t'(int'(p.x) + int'(a.dx))
                    && torpedo_pos.y == coord_t'(int'(p.y) + int'(a.dy)))
            else
            begin
                errors++;
                $display("torpedo step does not follow the new aim at %0t", $time);
            end
        end
        tick_density = 1;
        wait_end();
        tick_density = 0;
        while (m_state != S_ST)
        begin
            key = ($urandom % 3) == 0;   // ignored during the pause
            step_cycle();
        end
        finish_test("aim tracking", err0);

        // random games
        err0 = errors;
        wins = 0;
        for (int g = 0; g < 40; g++)
        begin
            tick_density = 0;
            wait_state(S_WK);
            tick_density = 1 + int'($urandom % 4);
            w = int'($urandom % 40);
            while (m_state == S_WK && w > 0)
            begin
                w--;
                step_cycle();
            end
            launch(sprite_vel_t'($urandom));
            while (m_state != S_ST)
            begin
                if ($urandom % 8 == 0)
                    aim = sprite_vel_t'($urandom);
                if ($urandom % 16 == 0)
                    key = 1'b1;
                if (m_state == S_WON && m_end_left == END_CYCLES)
                    wins++;
                step_cycle();
            end
        end
        tick_density = 0;
        $display("random games: %0d won of 40", wins);
        finish_test("random games", err0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* game_top.f */
hw/game_geom_pkg.sv
hw/game_ctrl_pkg.sv
hw/sprite_mover.sv
hw/sprite_collision.sv
hw/end_of_game_timer.sv
hw/game_master_fsm.sv
hw/game_top.sv
bench/game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the torpedo game testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module game_tb \
    -f game_top.f \
    -o game_sim

./obj_dir/game_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
